// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// Address and word widths of the core and of the read bus
	localparam int ADDR_BITS = 32;
	localparam int DATA_BITS = 32;

	// An address splits into {tag, line index, byte offset}
	localparam int LINE_WORDS   = 16;
	localparam int ICACHE_LINES = 16;
	localparam int OFFSET_BITS  = 6;
	localparam int INDEX_BITS   = 4;
	localparam int TAG_BITS     = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

	// Boot ROM behind the bus
	localparam int    ROM_WORDS      = 64;
	localparam int    ROM_INDEX_BITS = $clog2(ROM_WORDS);
	localparam int    ROM_WAIT       = 2;       // Cycles from start of a read to ready
	localparam int    ROM_CNT_BITS   = $clog2(ROM_WAIT + 1);
	localparam string ROM_IMAGE      = "sim/fetch_rom.hex";

	// Line-fill sequencer of the cache
	typedef enum logic {
		FILL_IDLE,
		FILL_BUSY
	} fill_state_t;

	// Current owner of the shared read bus
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_CACHE,
		ARB_DEBUG
	} arb_state_t;

	// ROM read sequence
	typedef enum logic [1:0] {
		ROM_IDLE,
		ROM_WAIT_ST,    // Counting wait states
		ROM_DONE        // Ready cycle and the cycle after it
	} rom_state_t;

endpackage

`default_nettype wire

// File: verilog/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               flush,

	// Core side
	input  wire  [fetch_pkg::ADDR_BITS-1:0]   rd_addr,
	input  wire                               rd_req,
	output logic                              rd_wait,
	output logic [fetch_pkg::DATA_BITS-1:0]   rd_data,

	// Read bus towards the arbiter
	output logic                              cache_req,
	input  wire                               cache_ack,
	output logic                              cache_rd,
	output logic [fetch_pkg::ADDR_BITS-1:0]   cache_addr,
	input  wire                               cache_ready,
	input  wire  [fetch_pkg::DATA_BITS-1:0]   bus_rdata
);
	import fetch_pkg::*;

	// Tag store and line data
	logic [ICACHE_LINES-1:0] line_valid;
	logic [TAG_BITS-1:0]     line_tag  [ICACHE_LINES];
	logic [DATA_BITS-1:0]    line_data [ICACHE_LINES][LINE_WORDS];

	// Fields of the core address
	logic [TAG_BITS-1:0]      rd_tag;
	logic [INDEX_BITS-1:0]    rd_index;
	logic [OFFSET_BITS-3:0]   rd_word;   // Word within the line
	logic [ADDR_BITS-OFFSET_BITS-1:0] rd_line;

	// Fill sequencer
	fill_state_t              fill_state;
	logic [OFFSET_BITS-3:0]   fill_word;
	logic [ADDR_BITS-OFFSET_BITS-1:0] fill_line;   // Tag and index of the line being filled
	logic [TAG_BITS-1:0]      fill_tag;
	logic [INDEX_BITS-1:0]    fill_index;

	logic hit;
	logic miss;
	logic abandon;
	logic word_done;
	logic last_word;

	assign rd_tag   = rd_addr[ADDR_BITS-1 -: TAG_BITS];
	assign rd_index = rd_addr[OFFSET_BITS +: INDEX_BITS];
	assign rd_word  = rd_addr[OFFSET_BITS-1:2];
	assign rd_line  = rd_addr[ADDR_BITS-1:OFFSET_BITS];

	assign fill_tag   = fill_line[ADDR_BITS-OFFSET_BITS-1 -: TAG_BITS];
	assign fill_index = fill_line[INDEX_BITS-1:0];

	// Hits are answered in the same cycle from the arrays
	assign hit  = line_valid[rd_index] && (line_tag[rd_index] == rd_tag);
	assign miss = rd_req && !hit;

	always_comb begin
		rd_wait = miss;
		rd_data = line_data[rd_index][rd_word];
	end

	// The core moved to another line or the cache is being flushed
	assign abandon = flush || (rd_line != fill_line);

	assign word_done = (fill_state == FILL_BUSY) && cache_ack && cache_ready && !abandon;
	assign last_word = fill_word == (OFFSET_BITS-2)'(LINE_WORDS - 1);

	// The request stays high for all words of the line
	assign cache_req  = fill_state == FILL_BUSY;
	assign cache_rd   = cache_req && cache_ack;
	assign cache_addr = {fill_line, fill_word, 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			fill_state <= FILL_IDLE;
			fill_word  <= '0;
			line_valid <= '0;
		end else begin
			case (fill_state)
				FILL_IDLE: begin
					if (miss && !flush) begin
						fill_state <= FILL_BUSY;
						fill_word  <= '0;
						// The old contents of this index get overwritten from here on
						line_valid[rd_index] <= 1'b0;
					end
				end
				FILL_BUSY: begin
					if (abandon) begin
						fill_state <= FILL_IDLE;
					end else if (word_done) begin
						fill_word <= fill_word + 1'b1;
						if (last_word) begin
							line_valid[fill_index] <= 1'b1;   // Valid on the edge of word 15
							fill_state <= FILL_IDLE;
						end
					end
				end
				default: fill_state <= FILL_IDLE;
			endcase

			if (flush)
				line_valid <= '0;   // Flush wins over a completing fill
		end
	end

	// Line address is latched while idle so it is ready when the fill starts
	always_ff @(posedge clk) begin
		if (fill_state == FILL_IDLE)
			fill_line <= rd_line;
		if (word_done) begin
			line_data[fill_index][fill_word] <= bus_rdata;
			if (last_word)
				line_tag[fill_index] <= fill_tag;
		end
	end

endmodule

`default_nettype wire

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire                               clk,
	input  wire                               rst,

	// Cache master
	input  wire                               cache_req,
	input  wire                               cache_rd,
	input  wire  [fetch_pkg::ADDR_BITS-1:0]   cache_addr,
	output logic                              cache_ack,
	output logic                              cache_ready,

	// Debug master
	input  wire                               dbg_req,
	input  wire  [fetch_pkg::ADDR_BITS-1:0]   dbg_addr,
	output logic                              dbg_ack,
	output logic                              dbg_ready,

	// ROM slave
	output logic                              rom_rd,
	output logic [fetch_pkg::ADDR_BITS-1:0]   rom_addr,
	input  wire                               rom_ready
);
	import fetch_pkg::*;

	arb_state_t arb_state;
	logic       last_dbg;   // Debug port won the last grant

	always_ff @(posedge clk) begin
		if (rst) begin
			arb_state <= ARB_IDLE;
			last_dbg  <= 1'b1;   // First contest goes to the cache
		end else begin
			case (arb_state)
				ARB_IDLE: begin
					if (cache_req && (!dbg_req || last_dbg)) begin
						arb_state <= ARB_CACHE;
						last_dbg  <= 1'b0;
					end else if (dbg_req) begin
						arb_state <= ARB_DEBUG;
						last_dbg  <= 1'b1;
					end
				end
				// A grant lasts until its master lets go of the request
				ARB_CACHE: if (!cache_req) arb_state <= ARB_IDLE;
				ARB_DEBUG: if (!dbg_req) arb_state <= ARB_IDLE;
				default:   arb_state <= ARB_IDLE;
			endcase
		end
	end

	assign cache_ack = arb_state == ARB_CACHE;
	assign dbg_ack   = arb_state == ARB_DEBUG;

	// Only the granted master reaches the ROM and sees its ready
	always_comb begin
		rom_rd      = 1'b0;
		rom_addr    = '0;
		cache_ready = 1'b0;
		dbg_ready   = 1'b0;
		case (arb_state)
			ARB_CACHE: begin
				rom_rd      = cache_rd;
				rom_addr    = cache_addr;
				cache_ready = rom_ready;
			end
			ARB_DEBUG: begin
				rom_rd    = dbg_req;   // One word per debug request
				rom_addr  = dbg_addr;
				dbg_ready = rom_ready;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/inst_rom.sv
`timescale 1ns/1ps
`default_nettype none

module inst_rom (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               rom_rd,
	input  wire  [fetch_pkg::ADDR_BITS-1:0]   rom_addr,
	output logic                              rom_ready,
	output logic [fetch_pkg::DATA_BITS-1:0]   rom_rdata
);
	import fetch_pkg::*;

	logic [DATA_BITS-1:0]      rom_mem [ROM_WORDS];
	rom_state_t                rom_state;
	logic [ROM_CNT_BITS-1:0]   wait_cnt;
	logic [ROM_INDEX_BITS-1:0] word_index;
	logic                      start;
	logic                      capture;

	initial $readmemh(ROM_IMAGE, rom_mem);

	// High address bits are ignored so the image repeats through the space
	assign word_index = rom_addr[2 +: ROM_INDEX_BITS];

	// A new word starts from idle, or one cycle after the previous ready
	assign start = rom_rd &&
		((rom_state == ROM_IDLE) || ((rom_state == ROM_DONE) && !rom_ready));

	always_comb begin
		if (rom_state == ROM_WAIT_ST)
			capture = rom_rd && (wait_cnt == ROM_CNT_BITS'(ROM_WAIT - 1));
		else
			capture = start && (ROM_WAIT == 1);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rom_state <= ROM_IDLE;
			rom_ready <= 1'b0;
			wait_cnt  <= '0;
		end else begin
			rom_ready <= capture;   // One-cycle pulse
			if (start) begin
				rom_state <= capture ? ROM_DONE : ROM_WAIT_ST;
				wait_cnt  <= ROM_CNT_BITS'(1);
			end else if (!rom_rd) begin
				rom_state <= ROM_IDLE;   // Read dropped by the master
			end else if (rom_state == ROM_WAIT_ST) begin
				if (capture)
					rom_state <= ROM_DONE;
				else
					wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			rom_rdata <= rom_mem[word_index];
	end

endmodule

`default_nettype wire

// File: verilog/fetch_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsystem (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               flush,

	// Core fetch port
	input  wire  [fetch_pkg::ADDR_BITS-1:0]   rd_addr,
	input  wire                               rd_req,
	output logic                              rd_wait,
	output logic [fetch_pkg::DATA_BITS-1:0]   rd_data,

	// Debug read port
	input  wire                               dbg_req,
	input  wire  [fetch_pkg::ADDR_BITS-1:0]   dbg_addr,
	output logic                              dbg_ack,
	output logic                              dbg_ready,
	output logic [fetch_pkg::DATA_BITS-1:0]   dbg_rdata
);
	import fetch_pkg::*;

	// Cache to arbiter
	logic                 cache_req;
	logic                 cache_ack;
	logic                 cache_rd;
	logic [ADDR_BITS-1:0] cache_addr;
	logic                 cache_ready;

	// Arbiter to ROM
	logic                 rom_rd;
	logic [ADDR_BITS-1:0] rom_addr;
	logic                 rom_ready;
	logic [DATA_BITS-1:0] bus_rdata;   // Shared by both masters

	assign dbg_rdata = bus_rdata;

	icache icache_i (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.rd_addr     (rd_addr),
		.rd_req      (rd_req),
		.rd_wait     (rd_wait),
		.rd_data     (rd_data),
		.cache_req   (cache_req),
		.cache_ack   (cache_ack),
		.cache_rd    (cache_rd),
		.cache_addr  (cache_addr),
		.cache_ready (cache_ready),
		.bus_rdata   (bus_rdata)
	);

	bus_arbiter bus_arbiter_i (
		.clk         (clk),
		.rst         (rst),
		.cache_req   (cache_req),
		.cache_rd    (cache_rd),
		.cache_addr  (cache_addr),
		.cache_ack   (cache_ack),
		.cache_ready (cache_ready),
		.dbg_req     (dbg_req),
		.dbg_addr    (dbg_addr),
		.dbg_ack     (dbg_ack),
		.dbg_ready   (dbg_ready),
		.rom_rd      (rom_rd),
		.rom_addr    (rom_addr),
		.rom_ready   (rom_ready)
	);

	inst_rom inst_rom_i (
		.clk       (clk),
		.rst       (rst),
		.rom_rd    (rom_rd),
		.rom_addr  (rom_addr),
		.rom_ready (rom_ready),
		.rom_rdata (bus_rdata)
	);

endmodule

`default_nettype wire

// File: sim/fetch_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsystem_tb;
	import fetch_pkg::*;

	localparam int MAX_CASES    = 64;
	localparam int RESET_CYCLES = 10;

	logic                 clk;
	logic                 rst;
	logic                 flush;
	logic [ADDR_BITS-1:0] rd_addr;
	logic                 rd_req;
	logic                 rd_wait;
	logic [DATA_BITS-1:0] rd_data;
	logic                 dbg_req;
	logic [ADDR_BITS-1:0] dbg_addr;
	logic                 dbg_ack;
	logic                 dbg_ready;
	logic [DATA_BITS-1:0] dbg_rdata;

	logic [DATA_BITS-1:0] image [ROM_WORDS];
	logic [7:0]           case_op   [MAX_CASES];
	logic [ADDR_BITS-1:0] case_addr [MAX_CASES];
	logic [DATA_BITS-1:0] case_exp  [MAX_CASES];
	int                   num_cases;

	// Expected state of the tag store
	logic                 model_valid [ICACHE_LINES];
	logic [TAG_BITS-1:0]  model_tag   [ICACHE_LINES];

	int checks;
	int data_errors;
	int wait_errors;
	int ack_errors;
	int load_errors;
	int cycle_cnt;
	int cycle_limit;   // Zero until the cases are loaded

	fetch_subsystem dut_i (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.rd_addr   (rd_addr),
		.rd_req    (rd_req),
		.rd_wait   (rd_wait),
		.rd_data   (rd_data),
		.dbg_req   (dbg_req),
		.dbg_addr  (dbg_addr),
		.dbg_ack   (dbg_ack),
		.dbg_ready (dbg_ready),
		.dbg_rdata (dbg_rdata)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("Run timed out after %0d cycles without finishing the cases", cycle_cnt);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic [DATA_BITS-1:0] image_word(input logic [ADDR_BITS-1:0] addr);
		return image[int'((addr >> 2) % ROM_WORDS)];   // ROM mirrors every 64 words
	endfunction

	function automatic int line_of(input logic [ADDR_BITS-1:0] addr);
		return int'((addr >> OFFSET_BITS) % ICACHE_LINES);
	endfunction

	function automatic logic [TAG_BITS-1:0] tag_of(input logic [ADDR_BITS-1:0] addr);
		return TAG_BITS'(addr >> (OFFSET_BITS + INDEX_BITS));
	endfunction

	task automatic load_cases();
		int fd;
		int ch;
		int n;
		num_cases = 0;
		fd = $fopen("sim/fetch_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open sim/fetch_cases.txt so no cases were run");
			load_errors++;
		end else begin
			ch = $fgetc(fd);
			while (ch != -1) begin
				if (ch == "#") begin
					while (ch != -1 && ch != "\n")
						ch = $fgetc(fd);   // Skip the rest of a comment line
				end else if (ch == "F" || ch == "D" || ch == "X" || ch == "B") begin
					case_op[num_cases] = 8'(ch);
					n = $fscanf(fd, "%h %h", case_addr[num_cases], case_exp[num_cases]);
					if (n != 2) begin
						$display("Case %0d in sim/fetch_cases.txt lacks an address or a word",
							num_cases);
						load_errors++;
					end
					num_cases++;
				end
				ch = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	task automatic check_word(input string what, input logic [ADDR_BITS-1:0] addr,
			input logic [DATA_BITS-1:0] got);
		logic [DATA_BITS-1:0] exp;
		exp = image_word(addr);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %0t ns: %s at %h returned %h, expected %h",
				$time, what, addr, got, exp);
			data_errors++;
		end
	endtask

	// A debug word can only come back while the debug port holds the grant
	task automatic check_grant(input logic [ADDR_BITS-1:0] addr);
		checks++;
		assert (dbg_ack === 1'b1) else begin
			$display("[FAIL] %0t ns: debug read at %h saw dbg_ready with dbg_ack %b",
				$time, addr, dbg_ack);
			ack_errors++;
		end
	endtask

	// Called on a falling edge, checks rd_wait within the same cycle
	task automatic begin_fetch(input logic [ADDR_BITS-1:0] addr);
		logic hit;
		hit = model_valid[line_of(addr)] && (model_tag[line_of(addr)] == tag_of(addr));
		rd_addr = addr;
		rd_req  = 1'b1;
		#1;
		checks++;
		assert (rd_wait === !hit) else begin
			$display("[FAIL] %0t ns: fetch at %h gave rd_wait %b, expected a %s",
				$time, addr, rd_wait, hit ? "hit" : "miss");
			wait_errors++;
		end
	endtask

	task automatic finish_fetch(input logic [ADDR_BITS-1:0] addr);
		check_word("fetch", addr, rd_data);
		model_valid[line_of(addr)] = 1'b1;   // The whole line is now resident
		model_tag[line_of(addr)]   = tag_of(addr);
		rd_req = 1'b0;
	endtask

	task automatic run_fetch(input logic [ADDR_BITS-1:0] addr);
		begin_fetch(addr);
		@(negedge clk);
		while (rd_wait)
			@(negedge clk);
		finish_fetch(addr);
	endtask

	task automatic run_debug(input logic [ADDR_BITS-1:0] addr);
		dbg_addr = addr;
		dbg_req  = 1'b1;
		@(negedge clk);
		while (!dbg_ready)
			@(negedge clk);
		check_grant(addr);
		check_word("debug read", addr, dbg_rdata);
		dbg_req = 1'b0;
	endtask

	task automatic run_flush();
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		for (int i = 0; i < ICACHE_LINES; i++)
			model_valid[i] = 1'b0;
	endtask

	// Debug read to another ROM word starts one cycle into the fill
	task automatic run_contended(input logic [ADDR_BITS-1:0] addr);
		logic fetch_done;
		logic dbg_done;
		begin_fetch(addr);
		@(negedge clk);
		dbg_addr   = addr ^ 32'h20;
		dbg_req    = 1'b1;
		fetch_done = 1'b0;
		dbg_done   = 1'b0;
		while (!(fetch_done && dbg_done)) begin
			@(negedge clk);
			if (dbg_req && dbg_ready) begin
				check_grant(dbg_addr);
				check_word("debug read during fill", dbg_addr, dbg_rdata);
				dbg_req  = 1'b0;
				dbg_done = 1'b1;
			end
			if (rd_req && !rd_wait) begin
				finish_fetch(addr);
				fetch_done = 1'b1;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		flush = 1'b0;
		rd_addr = '0;
		rd_req = 1'b0;
		dbg_req = 1'b0;
		dbg_addr = '0;
		checks = 0;
		data_errors = 0;
		wait_errors = 0;
		ack_errors = 0;
		load_errors = 0;
		cycle_cnt = 0;
		cycle_limit = 0;
		for (int i = 0; i < ICACHE_LINES; i++)
			model_valid[i] = 1'b0;
		$readmemh(ROM_IMAGE, image);
		load_cases();
		cycle_limit = num_cases * (LINE_WORDS * (ROM_WAIT + 1) + 8) + RESET_CYCLES + 200;

		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// Nothing is requested yet so the bus and the core port stay quiet
		checks++;
		assert (dbg_ack === 1'b0 && dbg_ready === 1'b0 && rd_wait === 1'b0) else begin
			$display("[FAIL] %0t ns: after reset dbg_ack %b dbg_ready %b rd_wait %b, expected 0",
				$time, dbg_ack, dbg_ready, rd_wait);
			ack_errors++;
		end

		for (int i = 0; i < num_cases; i++) begin
			if (case_op[i] != "X") begin
				checks++;
				assert (case_exp[i] === image_word(case_addr[i])) else begin
					$display("[FAIL] %0t ns: case %0d expects %h but the image holds %h",
						$time, i, case_exp[i], image_word(case_addr[i]));
					data_errors++;
				end
			end
			case (case_op[i])
				"F": run_fetch(case_addr[i]);
				"D": run_debug(case_addr[i]);
				"X": run_flush();
				"B": run_contended(case_addr[i]);
				default: ;
			endcase
		end

		$display("Checks: %0d, data errors: %0d, wait errors: %0d, ack errors: %0d, load errors: %0d",
			checks, data_errors, wait_errors, ack_errors, load_errors);
		if (data_errors + wait_errors + ack_errors + load_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: fetch_subsystem.f
verilog/fetch_pkg.sv
verilog/icache.sv
verilog/bus_arbiter.sv
verilog/inst_rom.sv
verilog/fetch_subsystem.sv
sim/fetch_subsystem_tb.sv

// File: Makefile
# Verilator build and regression for the fetch subsystem
TOP = fetch_subsystem_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f fetch_subsystem.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/fetch_rom.hex
E100FF03
E101FE07
E102FD0B
E103FC0F
E104FB13
E105FA17
E106F91B
E107F81F
E108F723
E109F627
E10AF52B
E10BF42F
E10CF333
E10DF237
E10EF13B
E10FF03F
E110EF43
E111EE47
E112ED4B
E113EC4F
E114EB53
E115EA57
E116E95B
E117E85F
E118E763
E119E667
E11AE56B
E11BE46F
E11CE373
E11DE277
E11EE17B
E11FE07F
E120DF83
E121DE87
E122DD8B
E123DC8F
E124DB93
E125DA97
E126D99B
E127D89F
E128D7A3
E129D6A7
E12AD5AB
E12BD4AF
E12CD3B3
E12DD2B7
E12ED1BB
E12FD0BF
E130CFC3
E131CEC7
E132CDCB
E133CCCF
E134CBD3
E135CAD7
E136C9DB
E137C8DF
E138C7E3
E139C6E7
E13AC5EB
E13BC4EF
E13CC3F3
E13DC2F7
E13EC1FB
E13FC0FF

// File: sim/fetch_cases.txt
# op addr expected: F fetch, D debug read, X flush, B fetch with a debug read pending
# expected is the ROM image word at (addr >> 2) mod 64, all values in hex
F 0000005C E117E85F
F 00000040 E110EF43
F 00000044 E111EE47
F 00000048 E112ED4B
F 0000004C E113EC4F
F 00000050 E114EB53
F 00000054 E115EA57
F 00000058 E116E95B
F 00000060 E118E763
F 00000064 E119E667
F 00000068 E11AE56B
F 0000006C E11BE46F
F 00000070 E11CE373
F 00000074 E11DE277
F 00000078 E11EE17B
F 0000007C E11FE07F
F 00000440 E110EF43
F 00000048 E112ED4B
F 00000444 E111EE47
D 00000088 E122DD8B
D 00001004 E101FE07
X 00000000 00000000
F 00000444 E111EE47
B 00000080 E120DF83
F 000000BC E12FD0BF
B 00000C00 E100FF03
F 00000C3C E10FF03F
F 00000000 E100FF03
